// ==== list.f ====
hw/cam_pkg.sv
hw/repl_if.sv
hw/cam_tag_array.sv
hw/cam_replacement.sv
hw/cam_top.sv
verif/cam_tb.sv

// ==== verif/cam_tb.sv ====
//==========================================================
// Self-checking testbench for the associative tag store
// Builds a table of operations with expected results from a
// small behavioral model of the store and its pseudo-LRU
// tree, then applies the rows one per cycle to the DUT
//==========================================================
`timescale 1ns/1ps

module cam_tb
   import cam_pkg::*;
();

   localparam int els_lp          = 8;
   localparam int tag_w_lp        = 12;
   localparam int data_w_lp       = 16;
   localparam int reset_cycles_lp = 5;

   // One operation and everything the DUT should answer with
   typedef struct {
      cam_op_e                op;
      logic [tag_w_lp-1:0]    tag;
      logic [data_w_lp-1:0]   data;
      logic                   exp_done;
      logic                   exp_hit;
      logic [data_w_lp-1:0]   exp_data;
      logic                   exp_evict;
      logic [tag_w_lp-1:0]    exp_evict_tag;
      logic [data_w_lp-1:0]   exp_evict_data;
   } row_t;

   logic                 clk_i;
   logic                 rst_i;
   cam_op_e              op_i;
   logic [tag_w_lp-1:0]  tag_i;
   logic [data_w_lp-1:0] data_i;
   logic                 done_o;
   logic                 hit_o;
   logic [data_w_lp-1:0] data_o;
   logic                 evict_o;
   logic [tag_w_lp-1:0]  evict_tag_o;
   logic [data_w_lp-1:0] evict_data_o;

   row_t rows_q[$];
   int   cycle_count;
   int   cycle_limit;

   // Model of the store contents and the tree bits in heap order
   logic                 m_valid [els_lp];
   logic [tag_w_lp-1:0]  m_tag [els_lp];
   logic [data_w_lp-1:0] m_data [els_lp];
   logic                 m_tree [els_lp-1];

   cam_top
   #(
      .els_p        (els_lp),
      .tag_width_p  (tag_w_lp),
      .data_width_p (data_w_lp)
   )
   dut_i
   (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .op_i         (op_i),
      .tag_i        (tag_i),
      .data_i       (data_i),
      .done_o       (done_o),
      .hit_o        (hit_o),
      .data_o       (data_o),
      .evict_o      (evict_o),
      .evict_tag_o  (evict_tag_o),
      .evict_data_o (evict_data_o)
   );

   always #50 clk_i = ~clk_i;

   // Stops the run at the first failure of any kind
   task automatic fail_run(input string why);
      $display("%s", why);
      $display("Simulation finished: FAIL");
      $fatal(1, "stopping at the first error");
   endtask

   task automatic report_mismatch(input string name, input logic [31:0] exp_v,
                                  input logic [31:0] act_v);
      fail_run($sformatf("MISMATCH time=%0t signal=%s expected=0x%0h actual=0x%0h",
                         $time, name, exp_v, act_v));
   endtask

   // Index of the valid entry holding the tag, or -1 when absent
   function automatic int find_tag(input logic [tag_w_lp-1:0] tag);
      for (int w = 0; w < els_lp; w++)
      begin
         if (m_valid[w] && m_tag[w] == tag)
         begin
            return w;
         end
      end
      return -1;
   endfunction

   // Take the lowest empty way first, or else follow the tree from
   // the root by halving the range of ways still in play
   function automatic int pick_victim();
      int node;
      int lo;
      int span;
      for (int w = 0; w < els_lp; w++)
      begin
         if (!m_valid[w])
         begin
            return w;
         end
      end
      node = 0;
      lo   = 0;
      span = els_lp;
      while (span > 1)
      begin
         span = span / 2;
         if (m_tree[node])
         begin
            lo   = lo + span;
            node = 2 * node + 2;
         end
         else
         begin
            node = 2 * node + 1;
         end
      end
      return lo;
   endfunction

   // Point each node on the way's path at the other half
   task automatic touch_way(input int way);
      int node;
      int lo;
      int span;
      node = 0;
      lo   = 0;
      span = els_lp;
      while (span > 1)
      begin
         span = span / 2;
         if (way < lo + span)
         begin
            m_tree[node] = 1'b1;
            node         = 2 * node + 1;
         end
         else
         begin
            m_tree[node] = 1'b0;
            lo           = lo + span;
            node         = 2 * node + 2;
         end
      end
   endtask

   // Works out the expected results of one operation and then moves the model on
   task automatic add_row(input cam_op_e op, input logic [tag_w_lp-1:0] tag,
                          input logic [data_w_lp-1:0] data);
      row_t r;
      int   idx;
      int   way;
      idx              = find_tag(tag);
      r.op             = op;
      r.tag            = tag;
      r.data           = data;
      // Lookups, writes and invalidates each answer with one done pulse
      r.exp_done       = (op == op_lookup) || (op == op_write) || (op == op_invalidate);
      r.exp_hit        = 1'b0;
      r.exp_data       = '0;
      r.exp_evict      = 1'b0;
      r.exp_evict_tag  = '0;
      r.exp_evict_data = '0;
      if (op == op_lookup && idx >= 0)
      begin
         r.exp_hit  = 1'b1;
         r.exp_data = m_data[idx];
         touch_way(idx);
      end
      else if (op == op_write && idx >= 0)
      begin
         r.exp_hit   = 1'b1;
         m_data[idx] = data;
         touch_way(idx);
      end
      else if (op == op_write)
      begin
         way = pick_victim();
         if (m_valid[way])
         begin
            r.exp_evict      = 1'b1;
            r.exp_evict_tag  = m_tag[way];
            r.exp_evict_data = m_data[way];
         end
         m_valid[way] = 1'b1;
         m_tag[way]   = tag;
         m_data[way]  = data;
         touch_way(way);
      end
      else if (op == op_invalidate && idx >= 0)
      begin
         r.exp_hit    = 1'b1;
         m_valid[idx] = 1'b0;
      end
      rows_q.push_back(r);
   endtask

   // Writes a fresh random data word that the row records
   task automatic add_write(input logic [tag_w_lp-1:0] tag);
      logic [data_w_lp-1:0] d;
      d = data_w_lp'($urandom());
      add_row(op_write, tag, d);
   endtask

   task automatic build_table();
      logic [tag_w_lp-1:0] order [7];
      for (int w = 0; w < els_lp; w++)
      begin
         m_valid[w] = 1'b0;
         m_tag[w]   = '0;
         m_data[w]  = '0;
      end
      for (int n = 0; n < els_lp - 1; n++)
      begin
         m_tree[n] = 1'b0;
      end
      // Empty store misses everything
      add_row(op_lookup, 12'h100, '0);
      add_row(op_lookup, 12'h2a5, '0);
      // Fill ways 0 to 7 and then read every tag back
      for (int t = 0; t < 8; t++)
      begin
         add_write(tag_w_lp'(12'h010 + t));
      end
      for (int t = 0; t < 8; t++)
      begin
         add_row(op_lookup, tag_w_lp'(12'h010 + t), '0);
      end
      // In-place update of a present tag
      add_write(12'h013);
      add_row(op_lookup, 12'h013, '0);
      // Touch order that shapes the tree before two evictions
      order = '{12'h016, 12'h011, 12'h014, 12'h010, 12'h017, 12'h012, 12'h015};
      for (int k = 0; k < 7; k++)
      begin
         add_row(op_lookup, order[k], '0);
      end
      add_write(12'h0a0);
      add_write(12'h0a1);
      // Emptied way is refilled ahead of the tree victim
      add_row(op_invalidate, 12'h0a0, '0);
      add_row(op_lookup, 12'h0a0, '0);
      add_write(12'h0b0);
      add_row(op_lookup, 12'h0b0, '0);
      // Absent tags and an idle cycle leave the victim order alone
      add_row(op_invalidate, 12'hfff, '0);
      add_row(op_lookup, 12'heee, '0);
      add_row(op_nop, 12'h000, '0);
      add_write(12'h0c0);
      add_write(12'h0c1);
      add_row(op_lookup, 12'h0c1, '0);
   endtask

   task automatic check_row(input row_t r);
      assert (done_o === r.exp_done)
      else report_mismatch("done_o", 32'(r.exp_done), 32'(done_o));
      assert (hit_o === r.exp_hit)
      else report_mismatch("hit_o", 32'(r.exp_hit), 32'(hit_o));
      assert (data_o === r.exp_data)
      else report_mismatch("data_o", 32'(r.exp_data), 32'(data_o));
      assert (evict_o === r.exp_evict)
      else report_mismatch("evict_o", 32'(r.exp_evict), 32'(evict_o));
      assert (evict_tag_o === r.exp_evict_tag)
      else report_mismatch("evict_tag_o", 32'(r.exp_evict_tag), 32'(evict_tag_o));
      assert (evict_data_o === r.exp_evict_data)
      else report_mismatch("evict_data_o", 32'(r.exp_evict_data), 32'(evict_data_o));
   endtask

   // Ends a run that has outlived reset plus the table plus slack
   always @(posedge clk_i)
   begin
      cycle_count = cycle_count + 1;
      if (cycle_count > cycle_limit)
      begin
         fail_run("Timeout: the table did not finish within the cycle limit");
      end
   end

   initial
   begin
      clk_i       = 1'b0;
      rst_i       = 1'b1;
      op_i        = op_nop;
      tag_i       = '0;
      data_i      = '0;
      cycle_count = 0;
      void'($urandom(32'h3946));
      build_table();
      cycle_limit = reset_cycles_lp + rows_q.size() + 20;
      repeat (reset_cycles_lp) @(posedge clk_i);
      rst_i <= 1'b0;
      // Row i goes out on an edge and its results are checked after the next one
      for (int i = 0; i <= rows_q.size(); i++)
      begin
         @(posedge clk_i);
         if (i < rows_q.size())
         begin
            op_i   <= rows_q[i].op;
            tag_i  <= rows_q[i].tag;
            data_i <= rows_q[i].data;
         end
         else
         begin
            op_i <= op_nop;
         end
         if (i > 0)
         begin
            @(negedge clk_i);
            check_row(rows_q[i-1]);
         end
      end
      $display("Simulation finished: PASS");
      $finish;
   end

endmodule : cam_tb

// ==== hw/cam_top.sv ====
//==========================================================
// Top level of the fully associative tag store
// Takes one operation per cycle on plain ports and answers
// one cycle later with done, hit, data and eviction results
// Set the entry count and widths here, they flow downward
//==========================================================
`timescale 1ns/1ps

module cam_top
   import cam_pkg::*;
#(
   // Number of entries, a power of two of at least 2
   parameter int els_p        = 8,
   // Width of the compared tag
   parameter int tag_width_p  = 12,
   // Width of the data word held with each tag
   parameter int data_width_p = 16
)
(
   input  logic                    clk_i,
   input  logic                    rst_i,

   // Request, sampled every cycle
   input  cam_op_e                 op_i,
   input  logic [tag_width_p-1:0]  tag_i,
   input  logic [data_width_p-1:0] data_i,

   // Response, registered one cycle after the request
   output logic                    done_o,
   output logic                    hit_o,
   output logic [data_width_p-1:0] data_o,

   // Entry pushed out by an allocating write
   output logic                    evict_o,
   output logic [tag_width_p-1:0]  evict_tag_o,
   output logic [data_width_p-1:0] evict_data_o
);

   // Touches, allocation strobe, empty vector and victim select
   repl_if
   #(
      .els_p (els_p)
   )
   repl ();

   // Storage and compare, owns all registered results
   cam_tag_array
   #(
      .els_p        (els_p),
      .tag_width_p  (tag_width_p),
      .data_width_p (data_width_p)
   )
   tag_array_i
   (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .op_i         (op_i),
      .tag_i        (tag_i),
      .data_i       (data_i),
      .repl         (repl.tag_side),
      .done_o       (done_o),
      .hit_o        (hit_o),
      .data_o       (data_o),
      .evict_o      (evict_o),
      .evict_tag_o  (evict_tag_o),
      .evict_data_o (evict_data_o)
   );

   // Pseudo-LRU tree
   // The victim it names is used by the tag array in the same cycle
   cam_replacement
   #(
      .els_p (els_p)
   )
   replacement_i
   (
      .clk_i (clk_i),
      .rst_i (rst_i),
      .repl  (repl.repl_side)
   );

endmodule : cam_top

// ==== hw/cam_replacement.sv ====
//==========================================================
// Tree pseudo-LRU replacement for the associative store
// Names a one-hot victim way every cycle, preferring the
// lowest empty way, and moves the tree away from each way
// that is hit or allocated; els_p must be a power of two
//==========================================================
`timescale 1ns/1ps

module cam_replacement
#(
   parameter int els_p = 8
)
(
   input  logic      clk_i,
   input  logic      rst_i,
   repl_if.repl_side repl
);

   // Width of a binary way index
   localparam int lg_els_lp = $clog2(els_p);

   // Tree bits in heap order, node 0 is the root
   // Children of node k sit at 2k+1 and 2k+2
   logic [els_p-2:0]     lru_r;
   logic [els_p-2:0]     lru_n;

   // Victim candidates
   logic [lg_els_lp-1:0] lru_way;
   logic [lg_els_lp-1:0] empty_way;
   logic                 empty_found;
   logic [lg_els_lp-1:0] victim_way;

   // Touch request for this cycle
   logic                 read_any;
   logic [lg_els_lp-1:0] read_way;
   logic [lg_els_lp-1:0] touch_way;
   logic                 touch_v;

   // Walk from the root to find the least recently used way
   // A clear bit sends the walk to the lower half of the subtree
   always_comb
   begin : lru_walk
      int unsigned node;
      node    = 0;
      lru_way = '0;
      for (int lvl = 0; lvl < lg_els_lp; lvl++)
      begin
         lru_way[lg_els_lp-1-lvl] = lru_r[node];
         node = 2 * node + 1 + lru_r[node];
      end
   end

   // Lowest-indexed empty way, scanned from the top down so
   // that the last assignment wins
   always_comb
   begin
      empty_found = 1'b0;
      empty_way   = '0;
      for (int i = els_p - 1; i >= 0; i--)
      begin
         if (repl.empty[i])
         begin
            empty_found = 1'b1;
            empty_way   = lg_els_lp'(i);
         end
      end
   end

   // Empty ways are filled before anything gets evicted
   assign victim_way = empty_found ? empty_way : lru_way;

   // Victim goes out one-hot
   assign repl.alloc_way = {{(els_p-1){1'b0}}, 1'b1} << victim_way;

   // Binary index of the hit way, read_v is one-hot
   always_comb
   begin
      read_way = '0;
      for (int i = 0; i < els_p; i++)
      begin
         if (repl.read_v[i])
         begin
            read_way = read_way | lg_els_lp'(i);
         end
      end
   end

   assign read_any = |repl.read_v;

   // The tag array never raises a hit and an allocation together,
   // so a single touch per cycle is enough
   assign touch_v   = read_any | repl.alloc_v;
   assign touch_way = read_any ? read_way : victim_way;

   // Every node on the touched path is pointed away from the way
   // Nodes off the path keep their value
   always_comb
   begin : lru_update
      int unsigned node;
      lru_n = lru_r;
      node  = 0;
      for (int lvl = 0; lvl < lg_els_lp; lvl++)
      begin
         lru_n[node] = ~touch_way[lg_els_lp-1-lvl];
         node = 2 * node + 1 + touch_way[lg_els_lp-1-lvl];
      end
   end

   // Tree state only moves on a touch
   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         lru_r <= '0;
      end
      else if (touch_v)
      begin
         lru_r <= lru_n;
      end
   end

endmodule : cam_replacement

// ==== hw/cam_tag_array.sv ====
//==========================================================
// Valid, tag and data storage of the associative store
// Compares the request tag against all entries in parallel,
// sequences lookup, write and invalidate, and registers the
// results for a latency of one cycle
//==========================================================
`timescale 1ns/1ps

module cam_tag_array
   import cam_pkg::*;
#(
   parameter int els_p        = 8,
   parameter int tag_width_p  = 12,
   parameter int data_width_p = 16
)
(
   input  logic                    clk_i,
   input  logic                    rst_i,
   input  cam_op_e                 op_i,
   input  logic [tag_width_p-1:0]  tag_i,
   input  logic [data_width_p-1:0] data_i,
   repl_if.tag_side                repl,
   output logic                    done_o,
   output logic                    hit_o,
   output logic [data_width_p-1:0] data_o,
   output logic                    evict_o,
   output logic [tag_width_p-1:0]  evict_tag_o,
   output logic [data_width_p-1:0] evict_data_o
);

   // Per-entry storage, only the valid bits carry reset
   logic [els_p-1:0]        valid_r;
   logic [tag_width_p-1:0]  tag_mem [els_p];
   logic [data_width_p-1:0] data_mem [els_p];

   // Compare results and operation decode
   logic [els_p-1:0]        match;
   logic                    hit_any;
   logic                    is_lookup;
   logic                    is_write;
   logic                    is_inval;
   logic                    write_hit;
   logic                    write_miss;
   logic                    evict_n;

   // One-hot selected words out of the arrays
   logic [data_width_p-1:0] hit_data;
   logic [tag_width_p-1:0]  victim_tag;
   logic [data_width_p-1:0] victim_data;

   assign is_lookup = (op_i == op_lookup);
   assign is_write  = (op_i == op_write);
   assign is_inval  = (op_i == op_invalidate);

   // Only valid entries take part in the compare
   // A tag is never held twice, so at most one bit is set
   always_comb
   begin
      for (int i = 0; i < els_p; i++)
      begin
         match[i] = valid_r[i] && (tag_mem[i] == tag_i);
      end
   end

   assign hit_any    = |match;
   assign write_hit  = is_write & hit_any;
   assign write_miss = is_write & ~hit_any;

   // The victim is only evicted when it already held an entry
   assign evict_n = write_miss & |(repl.alloc_way & valid_r);

   // Both selects are one-hot, so an OR tree acts as the mux
   always_comb
   begin
      hit_data    = '0;
      victim_tag  = '0;
      victim_data = '0;
      for (int i = 0; i < els_p; i++)
      begin
         if (match[i])
         begin
            hit_data = hit_data | data_mem[i];
         end
         if (repl.alloc_way[i])
         begin
            victim_tag  = victim_tag | tag_mem[i];
            victim_data = victim_data | data_mem[i];
         end
      end
   end

   // Hits on lookups and in-place writes make the way recent
   // Invalidates leave the tree alone
   assign repl.read_v  = match & {els_p{is_lookup | is_write}};
   assign repl.alloc_v = write_miss;
   assign repl.empty   = ~valid_r;

   // Valid bits are set by an allocation and cleared by an invalidate hit
   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         valid_r <= '0;
      end
      else
      begin
         for (int i = 0; i < els_p; i++)
         begin
            if (write_miss && repl.alloc_way[i])
            begin
               valid_r[i] <= 1'b1;
            end
            else if (is_inval && match[i])
            begin
               valid_r[i] <= 1'b0;
            end
         end
      end
   end

   // Tag and data payload
   // A write hit rewrites only the data, an allocation rewrites both
   always_ff @(posedge clk_i)
   begin
      for (int i = 0; i < els_p; i++)
      begin
         if ((write_hit && match[i]) || (write_miss && repl.alloc_way[i]))
         begin
            data_mem[i] <= data_i;
         end
         if (write_miss && repl.alloc_way[i])
         begin
            tag_mem[i] <= tag_i;
         end
      end
   end

   // Result flags, every non-nop operation gets one done pulse
   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         done_o  <= 1'b0;
         hit_o   <= 1'b0;
         evict_o <= 1'b0;
      end
      else
      begin
         done_o  <= (op_i != op_nop);
         hit_o   <= hit_any & (is_lookup | is_write | is_inval);
         evict_o <= evict_n;
      end
   end

   // Result payload, forced to zero when it carries nothing
   // data_o returns the stored word only on a lookup hit
   always_ff @(posedge clk_i)
   begin
      data_o       <= (is_lookup && hit_any) ? hit_data : '0;
      evict_tag_o  <= evict_n ? victim_tag : '0;
      evict_data_o <= evict_n ? victim_data : '0;
   end

endmodule : cam_tag_array

// ==== hw/repl_if.sv ====
//==========================================================
// Link between the tag array and the replacement block
// The tag array reports touches, allocations and empty ways
// and the replacement block answers with a one-hot victim
// Instantiate once per store with the same entry count
//==========================================================
`timescale 1ns/1ps

interface repl_if
#(
   parameter int els_p = 8
)
();

   // One-hot way that hit on a lookup or an in-place write
   logic [els_p-1:0] read_v;

   // Strobe for a write miss that allocates this cycle
   logic             alloc_v;

   // One bit per entry, set while the entry holds nothing
   logic [els_p-1:0] empty;

   // One-hot victim way, combinational from the tree and empty
   logic [els_p-1:0] alloc_way;

   // Storage side, owns the strobes and the empty vector
   modport tag_side (output read_v, output alloc_v, output empty, input alloc_way);

   // Policy side, owns the victim select
   modport repl_side (input read_v, input alloc_v, input empty, output alloc_way);

endinterface : repl_if

// ==== hw/cam_pkg.sv ====
//==========================================================
// Shared definitions for the fully associative tag store
// Holds the operation encoding seen on the op_i port of the
// top level, decoded by the tag array and driven by the
// testbench; import it where the op type is needed
//==========================================================

package cam_pkg;

   // Operation requested by the caller for the current cycle
   // One operation is accepted every cycle and none is ever stalled
   //
   // op_nop leaves the store untouched and raises no done pulse
   //
   // op_lookup compares the tag against every valid entry and
   // returns the stored data word on a hit
   //
   // op_write updates a matching entry in place, or allocates
   // the victim way chosen by the replacement block on a miss
   //
   // op_invalidate clears the valid bit of a matching entry and
   // does not touch the replacement state
   typedef enum logic [1:0]
   {
      op_nop        = 2'd0,
      op_lookup     = 2'd1,
      op_write      = 2'd2,
      op_invalidate = 2'd3
   } cam_op_e;

endpackage : cam_pkg
